//--- source/wb_bus_pkg.sv
// Wishbone bus widths, cycle-type codes and BE-32 lane swap helpers; import where bus types are used.

package wb_bus_pkg;

        // ------------------------------------------------------------
        // Bus widths.
        // ------------------------------------------------------------
        localparam int ADR_W = 32;
        localparam int DAT_W = 32;
        localparam int SEL_W = 4;
        localparam int CTI_W = 3;

        typedef logic [ADR_W-1:0] wb_adr_t;
        typedef logic [DAT_W-1:0] wb_dat_t;
        typedef logic [SEL_W-1:0] wb_sel_t;
        typedef logic [CTI_W-1:0] wb_cti_t;

        // Cycle type identifiers.
        localparam wb_cti_t CTI_CLASSIC = 3'd0;
        localparam wb_cti_t CTI_EOB     = 3'd7;

        // Low address bits dropped on word fetches.
        localparam int WORD_ALIGN_BITS = 2;

        // Lane 0 trades places with lane 3, lane 1 with lane 2.
        function automatic wb_sel_t be32_sel_swap(input wb_sel_t sel);
                return {sel[0], sel[1], sel[2], sel[3]};
        endfunction

        // Byte order of the word is reversed.
        function automatic wb_dat_t be32_dat_swap(input wb_dat_t dat);
                return {dat[7:0], dat[15:8], dat[23:16], dat[31:24]};
        endfunction

endpackage

//--- source/front_cfg_pkg.sv
// Bus front-end configuration and merger state encoding; import in the front-end modules.

package front_cfg_pkg;

        // ------------------------------------------------------------
        // Front-end configuration.
        // ------------------------------------------------------------

        // Swap byte lanes on the data path for BE-32 operation.
        localparam logic [0:0] BE_32_ENABLE = 1'b1;

        // Flip-flops per interrupt line.
        localparam int IRQ_SYNC_STAGES = 2;

        // Merger FSM states.
        typedef enum logic [1:0]
        {
                ST_IDLE = 2'd0,
                ST_CODE = 2'd1,
                ST_DATA = 2'd2
        } merger_state_t;

endpackage

//--- source/irq_synchronizer.sv
// Multi-rank synchronizer bringing the asynchronous IRQ and FIQ levels into the clock domain.

module irq_synchronizer
        import front_cfg_pkg::*;
(
        input  logic       i_clk,
        input  logic       i_rst_n,
        input  logic [1:0] i_async,
        output logic [1:0] o_sync
);

        // One entry per rank, index 0 faces the pins.
        logic [1:0] sync_q [IRQ_SYNC_STAGES];

        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                begin
                        for (int i = 0; i < IRQ_SYNC_STAGES; i++)
                                sync_q[i] <= '0;
                end
                else
                begin
                        sync_q[0] <= i_async;
                        for (int i = 1; i < IRQ_SYNC_STAGES; i++)
                                sync_q[i] <= sync_q[i-1];
                end
        end

        assign o_sync = sync_q[IRQ_SYNC_STAGES-1];

endmodule

//--- source/wb_merger.sv
// Arbiter merging the code fetch and data load/store masters onto one Wishbone classic bus.

module wb_merger
        import wb_bus_pkg::*;
        import front_cfg_pkg::*;
(
        input  logic    i_clk,
        input  logic    i_rst_n,

        // Code master, always a full word read.
        input  logic    i_code_stb,
        input  wb_adr_t i_code_adr,
        output logic    o_code_ack,
        output logic    o_code_err,

        // Data master.
        input  logic    i_data_stb,
        input  logic    i_data_we,
        input  wb_adr_t i_data_adr,
        input  wb_sel_t i_data_sel,
        input  wb_dat_t i_data_dat,
        output logic    o_data_ack,
        output logic    o_data_err,

        // Shared bus.
        output logic    o_wb_cyc,
        output logic    o_wb_stb,
        output logic    o_wb_we,
        output wb_adr_t o_wb_adr,
        output wb_dat_t o_wb_dat,
        output wb_sel_t o_wb_sel,
        output wb_cti_t o_wb_cti,
        input  logic    i_wb_ack,
        input  logic    i_wb_err
);

        merger_state_t state;

        // Set when the data master held the last grant.
        logic last_data;

        logic grant_code;
        logic grant_data;
        logic bus_done;

        // ------------------------------------------------------------
        // Grant selection.
        // ------------------------------------------------------------

        // On a tie the master that waited last time goes first.
        always_comb
        begin
                grant_code = 1'b0;
                grant_data = 1'b0;
                if (i_code_stb && i_data_stb)
                begin
                        grant_data = !last_data;
                        grant_code = last_data;
                end
                else
                begin
                        grant_data = i_data_stb;
                        grant_code = i_code_stb;
                end
        end

        assign bus_done = i_wb_ack | i_wb_err;

        // ------------------------------------------------------------
        // Control FSM.
        // ------------------------------------------------------------

        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                begin
                        state     <= ST_IDLE;
                        last_data <= 1'b0;
                        o_wb_cyc  <= 1'b0;
                        o_wb_stb  <= 1'b0;
                        o_wb_we   <= 1'b0;
                        o_wb_cti  <= CTI_CLASSIC;
                end
                else
                begin
                        case (state)
                        ST_IDLE:
                        begin
                                if (grant_data)
                                begin
                                        state     <= ST_DATA;
                                        last_data <= 1'b1;
                                        o_wb_cyc  <= 1'b1;
                                        o_wb_stb  <= 1'b1;
                                        o_wb_we   <= i_data_we;
                                        o_wb_cti  <= CTI_EOB;
                                end
                                else if (grant_code)
                                begin
                                        state     <= ST_CODE;
                                        last_data <= 1'b0;
                                        o_wb_cyc  <= 1'b1;
                                        o_wb_stb  <= 1'b1;
                                        o_wb_we   <= 1'b0;
                                        o_wb_cti  <= CTI_EOB;
                                end
                        end

                        ST_CODE, ST_DATA:
                        begin
                                // Single beat, so any response ends the cycle.
                                if (bus_done)
                                begin
                                        state    <= ST_IDLE;
                                        o_wb_cyc <= 1'b0;
                                        o_wb_stb <= 1'b0;
                                        o_wb_we  <= 1'b0;
                                        o_wb_cti <= CTI_CLASSIC;
                                end
                        end

                        default:
                        begin
                                state <= ST_IDLE;
                        end
                        endcase
                end
        end

        // Request fields, captured with the grant.
        always_ff @(posedge i_clk)
        begin
                if (state == ST_IDLE)
                begin
                        if (grant_data)
                        begin
                                o_wb_adr <= i_data_adr;
                                o_wb_sel <= i_data_sel;
                                o_wb_dat <= i_data_dat;
                        end
                        else if (grant_code)
                        begin
                                o_wb_adr <= {i_code_adr[ADR_W-1:WORD_ALIGN_BITS],
                                             {WORD_ALIGN_BITS{1'b0}}};
                                o_wb_sel <= '1;
                        end
                end
        end

        // Responses go to the owner of the bus only.
        assign o_code_ack = (state == ST_CODE) && i_wb_ack;
        assign o_code_err = (state == ST_CODE) && i_wb_err;
        assign o_data_ack = (state == ST_DATA) && i_wb_ack;
        assign o_data_err = (state == ST_DATA) && i_wb_err;

endmodule

//--- source/cpu_bus_front.sv
// Processor bus front end; top level with interrupt sync, master merging and BE-32 lane handling.

module cpu_bus_front
        import wb_bus_pkg::*;
        import front_cfg_pkg::*;
(
        input  logic    i_clk,
        input  logic    i_rst_n,

        // Level-triggered, active high.
        input  logic    i_irq,
        input  logic    i_fiq,
        output logic    o_irq,
        output logic    o_fiq,

        // Instruction fetch master.
        input  logic    i_code_stb,
        input  wb_adr_t i_code_adr,
        output wb_dat_t o_code_dat,
        output logic    o_code_ack,
        output logic    o_code_err,

        // Load/store master.
        input  logic    i_data_stb,
        input  logic    i_data_we,
        input  wb_adr_t i_data_adr,
        input  wb_sel_t i_data_sel,
        input  wb_dat_t i_data_dat,
        output wb_dat_t o_data_dat,
        output logic    o_data_ack,
        output logic    o_data_err,

        // Wishbone classic.
        output logic    o_wb_cyc,
        output logic    o_wb_stb,
        output logic    o_wb_we,
        output wb_adr_t o_wb_adr,
        output wb_dat_t o_wb_dat,
        output wb_sel_t o_wb_sel,
        output wb_cti_t o_wb_cti,
        input  logic    i_wb_ack,
        input  wb_dat_t i_wb_dat,
        input  logic    i_wb_err
);

        wb_sel_t data_sel_bus;

        irq_synchronizer u_irq_sync
        (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_async ({i_fiq, i_irq}),
                .o_sync  ({o_fiq, o_irq})
        );

        // ------------------------------------------------------------
        // BE-32 lanes on the data side.
        // ------------------------------------------------------------
        assign data_sel_bus = BE_32_ENABLE ? be32_sel_swap(i_data_sel) : i_data_sel;
        assign o_data_dat   = BE_32_ENABLE ? be32_dat_swap(i_wb_dat) : i_wb_dat;

        // Fetches are always words, lanes stay put.
        assign o_code_dat = i_wb_dat;

        wb_merger u_wb_merger
        (
                .i_clk      (i_clk),
                .i_rst_n    (i_rst_n),
                .i_code_stb (i_code_stb),
                .i_code_adr (i_code_adr),
                .o_code_ack (o_code_ack),
                .o_code_err (o_code_err),
                .i_data_stb (i_data_stb),
                .i_data_we  (i_data_we),
                .i_data_adr (i_data_adr),
                .i_data_sel (data_sel_bus),
                .i_data_dat (i_data_dat),
                .o_data_ack (o_data_ack),
                .o_data_err (o_data_err),
                .o_wb_cyc   (o_wb_cyc),
                .o_wb_stb   (o_wb_stb),
                .o_wb_we    (o_wb_we),
                .o_wb_adr   (o_wb_adr),
                .o_wb_dat   (o_wb_dat),
                .o_wb_sel   (o_wb_sel),
                .o_wb_cti   (o_wb_cti),
                .i_wb_ack   (i_wb_ack),
                .i_wb_err   (i_wb_err)
        );

endmodule

//--- bench/tb_clock_gen.sv
// Testbench clock and synchronous reset source; instantiate once in the bench top.

module tb_clock_gen
#(
        parameter int PERIOD     = 40,
        parameter int RST_CYCLES = 16
)
(
        output logic o_clk,
        output logic o_rst_n
);

        initial
        begin
                o_clk = 1'b0;
                forever #(PERIOD / 2) o_clk = ~o_clk;
        end

        // Release on a falling edge, away from the sampling edge.
        initial
        begin
                o_rst_n = 1'b0;
                repeat (RST_CYCLES) @(posedge o_clk);
                @(negedge o_clk);
                o_rst_n = 1'b1;
        end

endmodule

//--- bench/cpu_bus_front_tb.sv
// Directed testbench for the bus front end; run as the simulation top with a Wishbone responder.

module cpu_bus_front_tb
        import wb_bus_pkg::*;
();

        localparam int PERIOD        = 40;
        localparam int QUARTER       = PERIOD / 4;
        localparam int RST_CYCLES    = 16;
        localparam int ACCESS_CYCLES = 7;
        localparam int WORST_CYCLES  = RST_CYCLES + 4 + 8 * ACCESS_CYCLES + 10;
        localparam int TIMEOUT       = 2 * WORST_CYCLES * PERIOD;
        localparam logic [31:0] SEED = 32'h8afabdbc;
        localparam wb_dat_t RD_MASK  = 32'h5a3c_96e1;

        logic clk, rst_n, irq, fiq, o_irq, o_fiq;
        logic code_stb, o_code_ack, o_code_err;
        logic data_stb, data_we, o_data_ack, o_data_err;
        logic o_wb_cyc, o_wb_stb, o_wb_we, wb_ack, wb_err;
        wb_adr_t code_adr, data_adr, o_wb_adr;
        wb_sel_t data_sel, o_wb_sel;
        wb_dat_t data_dat, o_code_dat, o_data_dat, o_wb_dat, wb_dat;
        wb_cti_t o_wb_cti;

        int errors, checks, tests, test_mark, code_acks, data_acks;
        logic answer_err;
        wb_adr_t adr_log [$];

        tb_clock_gen #(.PERIOD(PERIOD), .RST_CYCLES(RST_CYCLES)) u_clock_gen
        (
                .o_clk   (clk),
                .o_rst_n (rst_n)
        );

        cpu_bus_front u_cpu_bus_front
        (
                .i_clk (clk), .i_rst_n (rst_n), .i_irq (irq), .i_fiq (fiq),
                .o_irq (o_irq), .o_fiq (o_fiq),
                .i_code_stb (code_stb), .i_code_adr (code_adr), .o_code_dat (o_code_dat),
                .o_code_ack (o_code_ack), .o_code_err (o_code_err),
                .i_data_stb (data_stb), .i_data_we (data_we), .i_data_adr (data_adr),
                .i_data_sel (data_sel), .i_data_dat (data_dat), .o_data_dat (o_data_dat),
                .o_data_ack (o_data_ack), .o_data_err (o_data_err),
                .o_wb_cyc (o_wb_cyc), .o_wb_stb (o_wb_stb), .o_wb_we (o_wb_we),
                .o_wb_adr (o_wb_adr), .o_wb_dat (o_wb_dat), .o_wb_sel (o_wb_sel),
                .o_wb_cti (o_wb_cti), .i_wb_ack (wb_ack), .i_wb_dat (wb_dat),
                .i_wb_err (wb_err)
        );

        // Slave read data rule.
        function automatic wb_dat_t read_value(input wb_adr_t adr);
                return adr ^ RD_MASK;
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                checks++;
                assert (got === exp)
                else
                begin
                        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
                        errors++;
                end
        endtask

        task automatic report_test(input string name);
                $display("Test %-14s %s, %0d errors", name,
                         (errors == test_mark) ? "ok" : "FAILED", errors - test_mark);
                test_mark = errors;
                tests++;
        endtask

        // Samples a quarter cycle after the falling edge until the master gets a reply.
        task automatic wait_reply(input logic to_data, output logic ack, output logic err);
                do
                begin
                        @(negedge clk);
                        #(QUARTER);
                        ack = to_data ? o_data_ack : o_code_ack;
                        err = to_data ? o_data_err : o_code_err;
                end
                while (!ack && !err);
        endtask

        // ------------------------------------------------------------
        // Bus responder and ack monitor.
        // ------------------------------------------------------------
        initial
        begin
                void'($urandom(SEED));
                wb_ack = 1'b0;
                wb_err = 1'b0;
                wb_dat = '0;
                forever
                begin
                        @(negedge clk);
                        wb_ack = 1'b0;
                        wb_err = 1'b0;
                        if (o_wb_stb)
                        begin
                                repeat ($urandom_range(3, 0)) @(negedge clk);
                                adr_log.push_back(o_wb_adr);
                                wb_dat = read_value(o_wb_adr);
                                if (answer_err)
                                        wb_err = 1'b1;
                                else
                                        wb_ack = 1'b1;
                        end
                end
        end

        always @(negedge clk)
        begin
                #(QUARTER / 2);
                if (o_code_ack)
                        code_acks++;
                if (o_data_ack)
                        data_acks++;
        end

        // ------------------------------------------------------------
        // Master tasks.
        // ------------------------------------------------------------
        task automatic code_access(input wb_adr_t adr);
                logic ack;
                logic err;
                wb_adr_t aligned;
                aligned = adr & ~32'h3;
                @(negedge clk);
                code_stb = 1'b1;
                code_adr = adr;
                wait_reply(1'b0, ack, err);
                check_value("o_code_ack", 32'(ack), 1);
                check_value("o_wb_cyc", 32'(o_wb_cyc), 1);
                check_value("o_wb_adr", o_wb_adr, aligned);
                check_value("o_wb_we", 32'(o_wb_we), 0);
                check_value("o_wb_sel", 32'(o_wb_sel), 32'hf);
                check_value("o_wb_cti", 32'(o_wb_cti), 32'(CTI_EOB));
                check_value("o_code_dat", o_code_dat, read_value(aligned));
                check_value("o_data_ack", 32'(o_data_ack), 0);
                @(negedge clk);
                code_stb = 1'b0;
        endtask

        task automatic data_access(input logic we, input wb_adr_t adr, input wb_sel_t sel,
                                   input wb_dat_t dat);
                logic ack;
                logic err;
                wb_sel_t sel_exp;
                wb_dat_t rd_val;
                wb_dat_t rd_exp;
                sel_exp = {<<{sel}};
                rd_val = read_value(adr);
                rd_exp = {<<8{rd_val}};
                @(negedge clk);
                data_stb = 1'b1;
                data_we = we;
                data_adr = adr;
                data_sel = sel;
                data_dat = dat;
                wait_reply(1'b1, ack, err);
                check_value("o_data_ack", 32'(ack), 1);
                check_value("o_wb_cyc", 32'(o_wb_cyc), 1);
                check_value("o_wb_adr", o_wb_adr, adr);
                check_value("o_wb_we", 32'(o_wb_we), 32'(we));
                check_value("o_wb_sel", 32'(o_wb_sel), 32'(sel_exp));
                check_value("o_code_ack", 32'(o_code_ack), 0);
                if (we)
                        check_value("o_wb_dat", o_wb_dat, dat);
                else
                        check_value("o_data_dat", o_data_dat, rd_exp);
                @(negedge clk);
                data_stb = 1'b0;
                data_we = 1'b0;
        endtask

        task automatic error_access(input logic to_data, input wb_adr_t adr);
                logic ack;
                logic err;
                int acks_before;
                acks_before = code_acks + data_acks;
                @(negedge clk);
                data_stb = to_data;
                data_adr = adr;
                data_sel = 4'hf;
                code_stb = !to_data;
                code_adr = adr;
                wait_reply(to_data, ack, err);
                check_value(to_data ? "o_data_err" : "o_code_err", 32'(err), 1);
                check_value(to_data ? "o_code_err" : "o_data_err",
                            32'(to_data ? o_code_err : o_data_err), 0);
                @(negedge clk);
                data_stb = 1'b0;
                code_stb = 1'b0;
                check_value("acks in error cycles", code_acks + data_acks - acks_before, 0);
        endtask

        // ------------------------------------------------------------
        // Tests.
        // ------------------------------------------------------------
        task automatic idle_outputs();
                check_value("o_wb_cyc", 32'(o_wb_cyc), 0);
                check_value("o_wb_stb", 32'(o_wb_stb), 0);
                check_value("o_code_ack", 32'(o_code_ack), 0);
                check_value("o_data_ack", 32'(o_data_ack), 0);
                check_value("o_irq", 32'(o_irq), 0);
                check_value("o_fiq", 32'(o_fiq), 0);
        endtask

        task automatic reset_values();
                repeat (4) @(negedge clk);
                #(QUARTER);
                idle_outputs();
                wait (rst_n === 1'b1);
                @(negedge clk);
                #(QUARTER);
                idle_outputs();
                report_test("reset state");
        endtask

        task automatic code_fetch();
                code_access(32'h0000_1236);
                report_test("code fetch");
        endtask

        task automatic data_lanes();
                data_access(1'b1, 32'h0000_2040, 4'b0011, 32'hcafe_f00d);
                data_access(1'b0, 32'h0000_2044, 4'b1110, 32'h0);
                report_test("data lanes");
        endtask

        task automatic arbitration();
                logic ack;
                logic err;
                int code_before;
                int data_before;
                // Code goes last, so the data master wins the tie.
                code_access(32'h0000_3000);
                code_before = code_acks;
                data_before = data_acks;
                adr_log.delete();
                @(negedge clk);
                code_stb = 1'b1;
                code_adr = 32'h0000_4007;
                data_stb = 1'b1;
                data_adr = 32'h0000_5004;
                data_sel = 4'hf;
                wait_reply(1'b1, ack, err);
                check_value("o_code_ack", 32'(o_code_ack), 0);
                @(negedge clk);
                data_stb = 1'b0;
                wait_reply(1'b0, ack, err);
                check_value("o_code_ack", 32'(ack), 1);
                @(negedge clk);
                code_stb = 1'b0;
                check_value("code ack count", code_acks - code_before, 1);
                check_value("data ack count", data_acks - data_before, 1);
                check_value("bus cycle count", adr_log.size(), 2);
                check_value("first o_wb_adr", adr_log[0], 32'h0000_5004);
                check_value("second o_wb_adr", adr_log[1], 32'h0000_4004);
                report_test("arbitration");
        endtask

        task automatic error_routing();
                answer_err = 1'b1;
                error_access(1'b1, 32'h0000_6008);
                error_access(1'b0, 32'h0000_700c);
                answer_err = 1'b0;
                report_test("error routing");
        endtask

        task automatic irq_timing();
                logic [1:0] seq [3] = '{2'b01, 2'b10, 2'b00};
                logic [1:0] prev;
                prev = 2'b00;
                foreach (seq[i])
                begin
                        @(negedge clk);
                        {fiq, irq} = seq[i];
                        @(negedge clk);
                        #(QUARTER);
                        check_value("o_irq after one edge", 32'(o_irq), 32'(prev[0]));
                        check_value("o_fiq after one edge", 32'(o_fiq), 32'(prev[1]));
                        @(negedge clk);
                        #(QUARTER);
                        check_value("o_irq after two edges", 32'(o_irq), 32'(seq[i][0]));
                        check_value("o_fiq after two edges", 32'(o_fiq), 32'(seq[i][1]));
                        prev = seq[i];
                end
                report_test("irq sync");
        endtask

        // Watchdog.
        initial
        begin
                #(TIMEOUT);
                $display("Timeout: the tests did not finish within %0d time units.", TIMEOUT);
                $display("Verification failed");
                $finish;
        end

        initial
        begin
                {errors, checks, tests, test_mark, code_acks, data_acks} = '0;
                answer_err = 1'b0;
                {irq, fiq, code_stb, data_stb, data_we} = '0;
                code_adr = '0;
                data_adr = '0;
                data_sel = '0;
                data_dat = '0;
                reset_values();
                code_fetch();
                data_lanes();
                arbitration();
                error_routing();
                irq_timing();
                $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
                if (errors == 0)
                        $display("Verification passed");
                else
                        $display("Verification failed");
                $finish;
        end

endmodule

//--- cpu_bus_front.f
source/wb_bus_pkg.sv
source/front_cfg_pkg.sv
source/irq_synchronizer.sv
source/wb_merger.sv
source/cpu_bus_front.sv
bench/tb_clock_gen.sv
bench/cpu_bus_front_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing -j 0
TOP       := cpu_bus_front_tb
DUT_TOP   := cpu_bus_front
FILELIST  := cpu_bus_front.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass line not found in $(LOG)." && exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
